//--- Bender.yml
package:
  name: mac_relu

sources:
  - mac_pkg.sv
  - cla_group4.sv
  - cla_adder.sv
  - signed_mult_pipe.sv
  - mac_accum.sv
  - requant_relu.sv
  - byte_packer.sv
  - mac_relu_top.sv
  - target: test
    files:
      - tb_mac_relu.sv

//--- byte_packer.sv
// packs four result bytes into one output word and drives the output handshake
`timescale 1ns/100ps
`default_nettype none

module byte_packer
  import mac_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              advance,
  input  logic [data_w-1:0] result,
  input  logic              result_valid,
  output logic              out_valid,
  input  logic              out_ready,
  output pixel_word_u       out_word,
  output logic              full_stall
);

  logic [$clog2(lanes)-1:0] lane_cnt;   // next lane to fill

  assign full_stall = out_valid;        // a finished word is waiting

  //////////////////////////////////////////////////
  // lane counter and output valid
  always_ff @(posedge clk) begin
    if (!rstn) begin
      lane_cnt  <= '0;
      out_valid <= 1'b0;
    end else if (advance) begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (result_valid) begin
        lane_cnt <= lane_cnt + 1'b1;    // wraps back to lane 0
        if (lane_cnt == lanes - 1) begin
          out_valid <= 1'b1;
        end
      end
    end
  end

  // lane 0 of the next word may fill on the same edge the old word leaves
  always_ff @(posedge clk) begin
    if (advance && result_valid) begin
      out_word.lane[lane_cnt] <= result;
    end
  end

  assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_word.raw))
    else $error("output word changed while held");

endmodule

`default_nettype wire

//--- cla_adder.sv
// width-parameterized carry-lookahead adder built from 4-bit groups
`timescale 1ns/100ps
`default_nettype none

module cla_adder #(
  parameter int width = 28   // multiple of 4
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  output logic [width-1:0] sum
);

  logic [width/4-1:0] grp_p;
  logic [width/4-1:0] grp_g;
  logic [width/4-1:0] grp_c;   // carry into each group

  assign grp_c[0] = 1'b0;      // add only, carry out of the top group is dropped

  for (genvar i = 0; i < width/4; i++) begin : g_grp

    // lookahead carry from the group below
    if (i > 0) begin : g_chain
      assign grp_c[i] = grp_g[i-1] | (grp_p[i-1] & grp_c[i-1]);
    end

    cla_group4 u_grp (
      .a     (a[4*i +: 4]),
      .b     (b[4*i +: 4]),
      .cin   (grp_c[i]),
      .sum   (sum[4*i +: 4]),
      .grp_p (grp_p[i]),
      .grp_g (grp_g[i])
    );

  end

endmodule

`default_nettype wire

//--- cla_group4.sv
// 4-bit carry-lookahead adder group with group propagate and generate
`timescale 1ns/100ps
`default_nettype none

module cla_group4 (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       grp_p,
  output logic       grp_g
);

  logic [3:0] p;
  logic [3:0] g;
  logic [3:0] c;   // carry into each bit

  assign p = a ^ b;
  assign g = a & b;

  // flattened lookahead, no ripple inside the group
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;

  // handed up to the chain between groups
  assign grp_p = &p;
  assign grp_g = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);

endmodule

`default_nettype wire

//--- flist.f
mac_pkg.sv
cla_group4.sv
cla_adder.sv
signed_mult_pipe.sv
mac_accum.sv
requant_relu.sv
byte_packer.sv
mac_relu_top.sv
tb_mac_relu.sv

//--- mac_accum.sv
// running accumulator that restarts on first beats and forwards the total on last beats
`timescale 1ns/100ps
`default_nettype none

module mac_accum
  import mac_pkg::*;
(
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     advance,
  input  logic signed [prod_w-1:0] product,
  input  mac_tag_t                 tag_in,
  output logic [acc_w-1:0]         total,
  output mac_tag_t                 tag_out
);

  logic [acc_w-1:0] prod_ext;
  logic [acc_w-1:0] base;
  logic [acc_w-1:0] sum;

  assign prod_ext = {{(acc_w-prod_w){product[prod_w-1]}}, product};
  assign base     = tag_in.first ? '0 : total;   // first beat drops the old total

  cla_adder #(.width(acc_w)) u_add (
    .a   (prod_ext),
    .b   (base),
    .sum (sum)
  );

  always_ff @(posedge clk) begin
    if (advance && tag_in.valid) begin
      total <= sum;   // bubbles leave the total alone
    end
  end

  // downstream only sees a group once it is complete
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tag_out.valid <= 1'b0;
    end else if (advance) begin
      tag_out       <= tag_in;
      tag_out.valid <= tag_in.valid & tag_in.last;
    end
  end

endmodule

`default_nettype wire

//--- mac_pkg.sv
// widths, quantization constants, and the beat, tag and output word types
`default_nettype none

package mac_pkg;

  localparam int data_w      = 8;    // feature, weight and bias bytes
  localparam int prod_w      = 16;
  localparam int acc_w       = 28;
  localparam int frac_shift  = 6;    // binary point of bias and result
  localparam int lanes       = 4;    // result bytes per output word
  localparam int mult_stages = 8;

  localparam logic [data_w-1:0] relu_max = 8'd127;

  // one input beat
  typedef struct packed {
    logic [data_w-1:0] feat;
    logic [data_w-1:0] weight;
    logic [data_w-1:0] bias;
    logic              first;   // opens a group
    logic              last;    // closes a group
  } mac_beat_t;

  // travels beside the arithmetic through every stage
  typedef struct packed {
    logic              valid;
    logic              first;
    logic              last;
    logic [data_w-1:0] bias;
  } mac_tag_t;

  // lane 0 sits in bits 7:0
  typedef union packed {
    logic [lanes*data_w-1:0]      raw;
    logic [lanes-1:0][data_w-1:0] lane;
  } pixel_word_u;

endpackage

`default_nettype wire

//--- mac_relu_top.sv
// MAC and ReLU top level with stall control and the pipeline instances
`timescale 1ns/100ps
`default_nettype none

module mac_relu_top
  import mac_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        in_valid,
  output logic        in_ready,
  input  mac_beat_t   in_beat,
  output logic        out_valid,
  input  logic        out_ready,
  output pixel_word_u out_word
);

  logic                     advance;
  logic                     full_stall;
  logic signed [prod_w-1:0] product;
  mac_tag_t                 mult_tag;
  logic [acc_w-1:0]         total;
  mac_tag_t                 acc_tag;
  logic [data_w-1:0]        result;
  logic                     result_valid;

  // the whole pipeline freezes only while a full word waits on the sink
  assign advance  = !full_stall || out_ready;
  assign in_ready = advance;

  //////////////////////////////////////////////////
  // datapath
  signed_mult_pipe u_mult (
    .clk      (clk),
    .rstn     (rstn),
    .advance  (advance),
    .beat     (in_beat),
    .in_valid (in_valid),
    .product  (product),
    .tag      (mult_tag)
  );

  mac_accum u_accum (
    .clk     (clk),
    .rstn    (rstn),
    .advance (advance),
    .product (product),
    .tag_in  (mult_tag),
    .total   (total),
    .tag_out (acc_tag)
  );

  requant_relu u_requant (
    .clk          (clk),
    .rstn         (rstn),
    .advance      (advance),
    .total        (total),
    .tag_in       (acc_tag),
    .result       (result),
    .result_valid (result_valid)
  );

  byte_packer u_packer (
    .clk          (clk),
    .rstn         (rstn),
    .advance      (advance),
    .result       (result),
    .result_valid (result_valid),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_word     (out_word),
    .full_stall   (full_stall)
  );

endmodule

`default_nettype wire

//--- requant_relu.sv
// bias add, ReLU and saturation of the group total to one result byte
`timescale 1ns/100ps
`default_nettype none

module requant_relu
  import mac_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  logic              advance,
  input  logic [acc_w-1:0]  total,
  input  mac_tag_t          tag_in,
  output logic [data_w-1:0] result,
  output logic              result_valid
);

  logic [acc_w-1:0]  bias_ext;
  logic [acc_w-1:0]  biased;
  logic [data_w-1:0] sat_byte;

  // bias is aligned to the fractional point of the total
  assign bias_ext = {{(acc_w-data_w-frac_shift){tag_in.bias[data_w-1]}},
                     tag_in.bias, {frac_shift{1'b0}}};

  cla_adder #(.width(acc_w)) u_bias_add (
    .a   (total),
    .b   (bias_ext),
    .sum (biased)
  );

  always_comb begin
    if (biased[acc_w-1]) begin
      sat_byte = '0;                                        // ReLU
    end else if (|biased[acc_w-2:frac_shift+data_w-1]) begin
      sat_byte = relu_max;                                  // above 127
    end else begin
      sat_byte = {1'b0, biased[frac_shift+data_w-2:frac_shift]};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      result <= sat_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result_valid <= 1'b0;
    end else if (advance) begin
      result_valid <= tag_in.valid;
    end
  end

endmodule

`default_nettype wire

//--- signed_mult_pipe.sv
// eight-stage sign-magnitude 8x8 multiplier with a staged adder tree
`timescale 1ns/100ps
`default_nettype none

module signed_mult_pipe
  import mac_pkg::*;
(
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     advance,
  input  mac_beat_t                beat,
  input  logic                     in_valid,
  output logic signed [prod_w-1:0] product,
  output mac_tag_t                 tag
);

  logic [data_w-1:0]      a_mag;
  logic [data_w-1:0]      b_mag;
  logic [data_w-1:0]      pp [data_w];   // partial product i has weight 2**i
  mac_tag_t               tag_new;

  logic [data_w-1:0]      pp_q [data_w];
  logic [5:0]             lo1_q [4];
  logic [2:0]             hi1a_q [4];
  logic [3:0]             hi1b_q [4];
  logic [9:0]             s1_q [4];
  logic [7:0]             lo2_q [2];
  logic [2:0]             hi2a_q [2];
  logic [4:0]             hi2b_q [2];
  logic [11:0]            s2_q [2];
  logic [9:0]             lo3_q;
  logic [2:0]             hi3a_q;
  logic [6:0]             hi3b_q;
  logic [prod_w-1:0]      mag_q;
  logic [mult_stages-2:0] sign_q;        // result sign, stages 1 to 7
  mac_tag_t               tag_q [mult_stages];

  assign a_mag = beat.feat[data_w-1] ? ~beat.feat + 1'b1 : beat.feat;
  assign b_mag = beat.weight[data_w-1] ? ~beat.weight + 1'b1 : beat.weight;

  always_comb begin
    for (int i = 0; i < data_w; i++) begin
      pp[i] = b_mag[i] ? a_mag : '0;
    end
  end

  assign tag_new = '{valid: in_valid, first: beat.first, last: beat.last, bias: beat.bias};

  //////////////////////////////////////////////////
  // adder tree, low bits in one stage and high bits plus carry in the next
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < data_w; i++) begin
        pp_q[i] <= pp[i];
      end
      sign_q <= {sign_q[mult_stages-3:0], beat.feat[data_w-1] ^ beat.weight[data_w-1]};
      // level 1, odd product weighted by 2
      for (int j = 0; j < 4; j++) begin
        lo1_q[j]  <= pp_q[2*j][4:0] + {pp_q[2*j+1][3:0], 1'b0};
        hi1a_q[j] <= pp_q[2*j][7:5];
        hi1b_q[j] <= pp_q[2*j+1][7:4];
      end
      for (int j = 0; j < 4; j++) begin
        s1_q[j] <= {5'(hi1a_q[j] + hi1b_q[j] + lo1_q[j][5]), lo1_q[j][4:0]};
      end
      // level 2, shift by two
      for (int k = 0; k < 2; k++) begin
        lo2_q[k]  <= s1_q[2*k][6:0] + {s1_q[2*k+1][4:0], 2'b00};
        hi2a_q[k] <= s1_q[2*k][9:7];
        hi2b_q[k] <= s1_q[2*k+1][9:5];
      end
      for (int k = 0; k < 2; k++) begin
        s2_q[k] <= {5'(hi2a_q[k] + hi2b_q[k] + lo2_q[k][7]), lo2_q[k][6:0]};
      end
      // level 3, shift by four
      lo3_q  <= s2_q[0][8:0] + {s2_q[1][4:0], 4'b0000};
      hi3a_q <= s2_q[0][11:9];
      hi3b_q <= s2_q[1][11:5];
      mag_q  <= {7'(hi3a_q + hi3b_q + lo3_q[9]), lo3_q[8:0]};
      // stage 8 puts the sign back
      product <= sign_q[mult_stages-2] ? -$signed(mag_q) : $signed(mag_q);
    end
  end

  //////////////////////////////////////////////////
  // tag shift register, one entry per stage
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int s = 0; s < mult_stages; s++) begin
        tag_q[s].valid <= 1'b0;
      end
    end else if (advance) begin
      tag_q[0] <= tag_new;
      for (int s = 1; s < mult_stages; s++) begin
        tag_q[s] <= tag_q[s-1];
      end
    end
  end

  assign tag = tag_q[mult_stages-1];

  assert property (@(posedge clk) disable iff (!rstn) !$isunknown(tag.valid))
    else $error("multiplier tag valid is unknown");

endmodule

`default_nettype wire

//--- tb_mac_relu.sv
// testbench for mac_relu_top with a stimulus table, reference model and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_mac_relu
  import mac_pkg::*;
;

  localparam int n_rows  = 20;   // a multiple of lanes
  localparam int max_len = 9;

  logic        clk;
  logic        rstn;
  logic        in_valid;
  logic        in_ready;
  mac_beat_t   in_beat;
  logic        out_valid;
  logic        out_ready;
  pixel_word_u out_word;

  // stimulus table with one group per row
  string             row_name [n_rows];
  int                row_len [n_rows];
  logic [data_w-1:0] row_feat [n_rows][max_len];
  logic [data_w-1:0] row_weight [n_rows][max_len];
  logic [data_w-1:0] row_bias [n_rows];
  logic [data_w-1:0] row_exp [n_rows];

  pixel_word_u exp_q[$];
  integer      seed     = 32'hea7a;
  integer      out_seed = 32'hea7a;
  int          checks   = 0;
  int          errors   = 0;
  int          watchdog_cycles;

  mac_relu_top UUT (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // checks
  task automatic check_word(input string name, input pixel_word_u exp, input pixel_word_u act);
    checks++;
    if (exp.raw !== act.raw) begin
      errors++;
      $display("error: %s expected %h actual %h", name, exp.raw, act.raw);
    end else begin
      $display("ok    %s word %h", name, act.raw);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error: %s expected %b actual %b", name, exp, act);
    end else begin
      $display("ok    %s", name);
    end
  endtask

  //////////////////////////////////////////////////
  // table and reference model
  task automatic set_row(input int r, input string name, input int len, input logic [7:0] f,
                         input logic [7:0] w, input logic [7:0] bias, input logic [7:0] exp);
    row_name[r] = name;
    row_len[r]  = len;
    row_bias[r] = bias;
    row_exp[r]  = exp;
    for (int i = 0; i < max_len; i++) begin
      row_feat[r][i]   = f;
      row_weight[r][i] = w;
    end
  endtask

  // dot product plus scaled bias, then ReLU and clip to 127
  function automatic logic [7:0] model_byte(input int r);
    int acc;
    acc = 0;
    for (int i = 0; i < row_len[r]; i++) begin
      acc += $signed(row_feat[r][i]) * $signed(row_weight[r][i]);
    end
    acc += $signed(row_bias[r]) * (1 << frac_shift);
    if (acc < 0) return 8'd0;
    if ((acc >> frac_shift) > 127) return 8'd127;
    return 8'(acc >> frac_shift);
  endfunction

  task automatic build_table();
    set_row(0, "neg_x_neg", 1, 8'h80, 8'h80, 8'd0, 8'd127);     // 16384 saturates
    set_row(1, "neg_prod", 1, 8'd50, 8'hfd, 8'd0, 8'd0);        // 50 * -3
    set_row(2, "small_pos", 1, 8'd10, 8'd20, 8'd0, 8'd3);
    set_row(3, "pos_pos", 1, 8'd64, 8'd64, 8'd0, 8'd64);
    set_row(4, "dot9_ramp", 9, 8'd0, 8'd16, 8'd0, 8'd11);       // 720 total
    for (int i = 0; i < max_len; i++) begin
      row_feat[4][i] = 8'(i + 1);
    end
    set_row(5, "dot9_restart", 9, 8'd8, 8'd8, 8'd0, 8'd9);      // would be 20 without restart
    set_row(6, "bias_neg", 1, 8'd40, 8'd40, 8'he2, 8'd0);       // bias -30
    set_row(7, "bias_sat", 1, 8'd60, 8'd60, 8'd100, 8'd127);
    for (int r = 8; r < n_rows; r++) begin
      set_row(r, $sformatf("rand%0d", r), 1 + ($unsigned($random(seed)) % max_len),
              8'd0, 8'd0, 8'($random(seed)), 8'd0);
      for (int i = 0; i < max_len; i++) begin
        row_feat[r][i]   = 8'($random(seed));
        row_weight[r][i] = 8'($random(seed));
      end
      row_exp[r] = model_byte(r);
    end
  endtask

  function automatic mac_beat_t make_beat(input int r, input int b);
    mac_beat_t beat;
    beat.feat   = row_feat[r][b];
    beat.weight = row_weight[r][b];
    beat.bias   = row_bias[r];
    beat.first  = (b == 0);
    beat.last   = (b == row_len[r] - 1);
    return beat;
  endfunction

  //////////////////////////////////////////////////
  // input and output sides
  task automatic send_pass(input bit throttle);
    int          r;
    int          b;
    int          lane;
    pixel_word_u exp_w;
    r     = 0;
    b     = 0;
    lane  = 0;
    exp_w = '0;
    while (r < n_rows) begin
      @(posedge clk);
      if (in_valid && in_ready) begin
        b++;
        if (b == row_len[r]) begin
          exp_w.lane[lane] = row_exp[r];   // earliest group lands in lane 0
          lane++;
          if (lane == lanes) begin
            exp_q.push_back(exp_w);
            lane = 0;
          end
          b = 0;
          r++;
        end
      end else if (in_valid) begin
        continue;   // beat held until taken
      end
      if (r == n_rows) begin
        in_valid <= 1'b0;
      end else if (throttle && ($random(seed) & 3) == 0) begin
        in_valid <= 1'b0;
      end else begin
        in_valid <= 1'b1;
        in_beat  <= make_beat(r, b);
      end
    end
  endtask

  task automatic receive_pass(input int pass, input bit throttle);
    int got;
    got = 0;
    while (got < n_rows / lanes) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("an output word arrived while no word was expected");
        end else begin
          check_word($sformatf("pass%0d_word%0d", pass, got), exp_q.pop_front(), out_word);
        end
        got++;
      end
      out_ready <= throttle ? (($random(out_seed) & 3) != 0) : 1'b1;
    end
    out_ready <= 1'b1;
  endtask

  initial begin
    int total_beats;
    rstn      = 1'b0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    build_table();
    total_beats = 0;
    for (int r = 0; r < n_rows; r++) begin
      total_beats += 2 * row_len[r];   // two passes over the table
    end
    watchdog_cycles = total_beats * 8 + 200;
    fork
      begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
      end
    join_none

    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_flag("reset_out_valid_low", 1'b0, out_valid);
    check_flag("reset_in_ready_high", 1'b1, in_ready);
    out_ready <= 1'b1;

    // full rate, then random gaps on both sides
    fork
      send_pass(1'b0);
      receive_pass(0, 1'b0);
    join
    fork
      send_pass(1'b1);
      receive_pass(1, 1'b1);
    join

    // a stray word would be held here and stay visible
    out_ready <= 1'b0;
    repeat (16) @(posedge clk);
    check_flag("no_extra_word", 1'b0, out_valid);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected words never arrived", exp_q.size());
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
